// ==== Bender.yml ====
package:
  name: gpu

sources:
  # Package first, stages in pipeline order, top level last
  - files:
      - gpu_pkg.sv
      - scan_timing.sv
      - vram_fetch.sv
      - palette_ram.sv
      - color_out.sv
      - gpu.sv

  # Simulation only
  - target: test
    files:
      - gpu_tb.sv

// ==== color_out.sv ====
`timescale 1ns/1ps

module color_out (
  input  logic                               clk,
  input  logic                               rst_n,
  input  gpu_pkg::lookup_t                   lookup,
  output logic [gpu_pkg::RGB_COLOR_DEPTH-1:0] rgb,
  output logic                               de,
  output logic [gpu_pkg::SCREEN_X_WIDTH-1:0]  px_x,
  output logic [gpu_pkg::SCREEN_Y_WIDTH-1:0]  px_y
);
  import gpu_pkg::*;

  localparam int CH_BITS = RGB_COLOR_DEPTH / 3;  // Kept bits per channel

  logic [RGB_COLOR_DEPTH-1:0] rgb_trunc;

  // Top bits of each 8-bit channel
  assign rgb_trunc = {
    lookup.color[23 -: CH_BITS],  // Red
    lookup.color[15 -: CH_BITS],  // Green
    lookup.color[7 -: CH_BITS]    // Blue
  };

  always_ff @(posedge clk) begin
    px_x <= lookup.x;
    px_y <= lookup.y;
    if (!rst_n) begin
      rgb <= '0;
      de  <= 1'b0;
    end else begin
      rgb <= lookup.blank ? '0 : rgb_trunc;  // Black in blanking
      de  <= !lookup.blank;
    end
  end

endmodule

// ==== gpu.f ====
gpu_pkg.sv
scan_timing.sv
vram_fetch.sv
palette_ram.sv
color_out.sv
gpu.sv
gpu_tb.sv

// ==== gpu.sv ====
`timescale 1ns/1ps

module gpu #(
  parameter int H_ACTIVE = 640,
  parameter int H_TOTAL  = 800,
  parameter int V_ACTIVE = 480,
  parameter int V_TOTAL  = 525
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // Host palette port
  input  gpu_pkg::pal_req_t                   pal_req,
  output logic [gpu_pkg::MPU_DATA_WIDTH-1:0]  pal_rdata,
  output logic                                pal_rvalid,
  // VRAM read port
  output logic [gpu_pkg::VRAM_ADDR_WIDTH-1:0] vram_addr,
  output logic                                vram_en,
  input  logic [gpu_pkg::VRAM_DATA_WIDTH-1:0] vram_data,
  // Pixel output
  output logic [gpu_pkg::RGB_COLOR_DEPTH-1:0] rgb,
  output logic                                de,
  output logic [gpu_pkg::SCREEN_X_WIDTH-1:0]  px_x,
  output logic [gpu_pkg::SCREEN_Y_WIDTH-1:0]  px_y
);
  import gpu_pkg::*;

  scan_t   scan;    // Counter output
  fetch_t  fetch;   // Two cycles later
  lookup_t lookup;  // Three cycles later

  scan_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_ACTIVE (V_ACTIVE),
    .V_TOTAL  (V_TOTAL)
  ) scan_i (
    .clk   (clk),
    .rst_n (rst_n),
    .scan  (scan)
  );

  vram_fetch fetch_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .scan      (scan),
    .vram_addr (vram_addr),
    .vram_en   (vram_en),
    .vram_data (vram_data),
    .fetch     (fetch)
  );

  palette_ram palette_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pal_req    (pal_req),
    .pal_rdata  (pal_rdata),
    .pal_rvalid (pal_rvalid),
    .fetch      (fetch),
    .lookup     (lookup)
  );

  // Last stage, four cycles after the counters
  color_out color_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .lookup (lookup),
    .rgb    (rgb),
    .de     (de),
    .px_x   (px_x),
    .px_y   (px_y)
  );

endmodule

// ==== gpu_pkg.sv ====
package gpu_pkg;

  // Host palette port
  localparam int PAL_ADDR_WIDTH  = 10;  // Bit 0 picks the entry half
  localparam int PAL_INDEX_WIDTH = 9;   // 512 entries
  localparam int PAL_DATA_WIDTH  = 24;  // {red, green, blue}
  localparam int PAL_ENTRIES     = 1 << PAL_INDEX_WIDTH;
  localparam int MPU_DATA_WIDTH  = 16;

  // Video RAM, one word per 4x4 block
  localparam int VRAM_ADDR_WIDTH = 16;  // {y[9:2], x[9:2]}
  localparam int VRAM_DATA_WIDTH = 16;  // Index in the low bits

  // Display side
  localparam int RGB_COLOR_DEPTH = 18;  // Six bits per channel
  localparam int SCREEN_X_WIDTH  = 10;
  localparam int SCREEN_Y_WIDTH  = 10;

  // One host access, wr or rd for a single cycle
  typedef struct packed {
    logic                      wr;
    logic                      rd;
    logic [1:0]                be;     // Active high byte enables
    logic [PAL_ADDR_WIDTH-1:0] addr;
    logic [MPU_DATA_WIDTH-1:0] wdata;
  } pal_req_t;

  // Timing stage output
  typedef struct packed {
    logic [SCREEN_X_WIDTH-1:0] x;
    logic [SCREEN_Y_WIDTH-1:0] y;
    logic                      blank;
  } scan_t;

  // Fetch stage output, index already extracted
  typedef struct packed {
    logic [SCREEN_X_WIDTH-1:0]  x;
    logic [SCREEN_Y_WIDTH-1:0]  y;
    logic                       blank;
    logic [PAL_INDEX_WIDTH-1:0] index;
  } fetch_t;

  // Palette stage output, full color
  typedef struct packed {
    logic [SCREEN_X_WIDTH-1:0] x;
    logic [SCREEN_Y_WIDTH-1:0] y;
    logic                      blank;
    logic [PAL_DATA_WIDTH-1:0] color;
  } lookup_t;

endpackage

// ==== gpu_tb.sv ====
`timescale 1ns/1ps

module gpu_tb;
  import gpu_pkg::*;

  localparam int H_ACTIVE     = 32;
  localparam int H_TOTAL      = 40;
  localparam int V_ACTIVE     = 16;
  localparam int V_TOTAL      = 20;
  localparam int RESET_CYCLES = 10;
  localparam int ROWS         = 16;
  localparam int ENTRIES      = 8;                  // Distinct palette entries written
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int WRITE_CYCLES = ROWS * 2;           // Two host addresses per row
  localparam int READ_CYCLES  = ENTRIES * 2 * 2;    // Both halves, two cycles each
  // Reset and the wait for a frame start counted as well
  localparam int CYCLE_LIMIT  =
    2 * (RESET_CYCLES + WRITE_CYCLES + READ_CYCLES + 3 * FRAME_CYCLES);
  localparam logic [31:0] SEED = 32'hef0f0152;

  // One palette table row
  typedef struct packed {
    logic [PAL_INDEX_WIDTH-1:0] index;
    logic [PAL_DATA_WIDTH-1:0]  color;
    logic [2:0]                 be;     // {red, green, blue}
  } pal_row_t;

  logic                       clk;
  logic                       rst_n;
  pal_req_t                   pal_req;
  logic [MPU_DATA_WIDTH-1:0]  pal_rdata;
  logic                       pal_rvalid;
  logic [VRAM_ADDR_WIDTH-1:0] vram_addr;
  logic                       vram_en;
  logic [VRAM_DATA_WIDTH-1:0] vram_data;
  logic [RGB_COLOR_DEPTH-1:0] rgb;
  logic                       de;
  logic [SCREEN_X_WIDTH-1:0]  px_x;
  logic [SCREEN_Y_WIDTH-1:0]  px_y;

  logic [VRAM_DATA_WIDTH-1:0] vram [1 << VRAM_ADDR_WIDTH];  // VRAM model contents
  pal_row_t                   pal_table [ROWS];
  logic [PAL_DATA_WIDTH-1:0]  exp_pal [ENTRIES];            // Reference palette
  int unsigned                cycles;
  int unsigned                checks;
  int unsigned                errors;

  gpu #(
    .H_ACTIVE (H_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_ACTIVE (V_ACTIVE),
    .V_TOTAL  (V_TOTAL)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pal_req    (pal_req),
    .pal_rdata  (pal_rdata),
    .pal_rvalid (pal_rvalid),
    .vram_addr  (vram_addr),
    .vram_en    (vram_en),
    .vram_data  (vram_data),
    .rgb        (rgb),
    .de         (de),
    .px_x       (px_x),
    .px_y       (px_y)
  );

  always #20 clk = ~clk;  // 40 ns period

  // Word for the address registered at the last edge, taken by the DUT at the next
  assign vram_data = (vram_en === 1'b1) ? vram[vram_addr] : '0;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Upper six bits of each channel
  function automatic logic [RGB_COLOR_DEPTH-1:0] truncate_color(input logic [23:0] c);
    return {c[23:18], c[15:10], c[7:2]};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("ERROR %0t %s: got %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("At %0t: %s", $time, what);
  endtask

  task automatic load_table();
    pal_table[0]  = {9'd0, 24'hff8040, 3'b111};
    pal_table[1]  = {9'd1, 24'h13579b, 3'b111};
    pal_table[2]  = {9'd2, 24'hfedcba, 3'b111};
    pal_table[3]  = {9'd3, 24'h0f1e2d, 3'b111};
    pal_table[4]  = {9'd4, 24'ha5c3e1, 3'b111};
    pal_table[5]  = {9'd5, 24'h7e817f, 3'b111};
    pal_table[6]  = {9'd6, 24'h00ff00, 3'b111};
    pal_table[7]  = {9'd7, 24'hc0ffee, 3'b111};
    pal_table[8]  = {9'd2, 24'h123456, 3'b001};  // Blue only
    pal_table[9]  = {9'd5, 24'h9abcde, 3'b010};  // Green only
    pal_table[10] = {9'd0, 24'h3c4d5e, 3'b100};  // Red only
    pal_table[11] = {9'd6, 24'h6b7c8d, 3'b011};  // Red kept
    pal_table[12] = {9'd3, 24'he1d2c3, 3'b101};  // Green kept
    pal_table[13] = {9'd7, 24'h445566, 3'b110};  // Blue kept
    pal_table[14] = {9'd1, 24'hdeadbe, 3'b000};  // No lane, entry unchanged
    pal_table[15] = {9'd4, 24'h2468ac, 3'b111};
  endtask

  // Single-cycle write strobe, the next access replaces it
  task automatic host_write(input logic [PAL_ADDR_WIDTH-1:0] addr, input logic [1:0] be,
                            input logic [MPU_DATA_WIDTH-1:0] data);
    pal_req_t req;
    req       = '0;
    req.wr    = 1'b1;
    req.be    = be;
    req.addr  = addr;
    req.wdata = data;
    @(posedge clk);
    pal_req <= req;
  endtask

  // Read strobe, then rvalid and data one cycle later
  task automatic host_read_check(input logic [PAL_ADDR_WIDTH-1:0] addr,
                                 input logic [MPU_DATA_WIDTH-1:0] exp_data);
    pal_req_t req;
    req      = '0;
    req.rd   = 1'b1;
    req.addr = addr;
    @(posedge clk);
    pal_req <= req;
    @(negedge clk);
    checks++;
    if (pal_rvalid !== 1'b0) begin
      report_mismatch("pal_rvalid", pal_rvalid, 0);
    end
    @(posedge clk);
    pal_req <= '0;
    @(negedge clk);
    checks++;
    if (pal_rvalid !== 1'b1) begin
      report_mismatch("pal_rvalid", pal_rvalid, 1);
    end
    checks++;
    if (pal_rdata !== exp_data) begin
      report_mismatch("pal_rdata", pal_rdata, exp_data);
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, run stopped after %0d cycles without reaching the end", cycles);
      $display("Finished: %0d checks, %0d errors", checks, errors + 1);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    pal_row_t                   row;
    logic [31:0]                state;
    logic [VRAM_ADDR_WIDTH-1:0] blk;
    logic [RGB_COLOR_DEPTH-1:0] exp_rgb;
    logic                       active;
    int                         ex_x;
    int                         ex_y;
    int                         de_count;
    clk     = 1'b0;
    rst_n   = 1'b0;
    pal_req = '0;
    cycles  = 0;
    checks  = 0;
    errors  = 0;
    load_table();
    state = SEED;
    for (int a = 0; a < (1 << VRAM_ADDR_WIDTH); a++) begin
      state   = xorshift32(state);
      vram[a] = state[15:0] & 16'hfe07;  // Index bits 8:3 cleared, upper bits left random
    end

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);  // Outputs still hold reset values
    checks += 4;
    if (de !== 1'b0) begin
      report_mismatch("de", de, 0);
    end
    if (vram_en !== 1'b0) begin
      report_mismatch("vram_en", vram_en, 0);
    end
    if (pal_rvalid !== 1'b0) begin
      report_mismatch("pal_rvalid", pal_rvalid, 0);
    end
    if (rgb !== '0) begin
      report_mismatch("rgb", rgb, 0);
    end

    // Palette table as host writes, reference follows the lane rule
    for (int r = 0; r < ROWS; r++) begin
      row = pal_table[r];
      host_write({row.index, 1'b0}, row.be[1:0], row.color[15:0]);
      host_write({row.index, 1'b1}, {1'b1, row.be[2]}, {8'h5a, row.color[23:16]});
      for (int lane = 0; lane < 3; lane++) begin
        if (row.be[lane]) begin
          exp_pal[row.index][lane*8 +: 8] = row.color[lane*8 +: 8];
        end
      end
    end

    // Readback of both halves
    for (int e = 0; e < ENTRIES; e++) begin
      host_read_check({e[PAL_INDEX_WIDTH-1:0], 1'b0}, exp_pal[e][15:0]);
      host_read_check({e[PAL_INDEX_WIDTH-1:0], 1'b1}, {8'h00, exp_pal[e][23:16]});
    end
    @(negedge clk);
    checks++;
    if (pal_rvalid !== 1'b0) begin
      report_mismatch("pal_rvalid", pal_rvalid, 0);
    end

    // Wait for the first pixel of a frame
    while (!(px_x === '0 && px_y === '0)) begin
      @(negedge clk);
    end
    ex_x     = 0;
    ex_y     = 0;
    de_count = 0;
    for (int n = 0; n < 2 * FRAME_CYCLES; n++) begin
      checks += 4;
      if (px_x !== SCREEN_X_WIDTH'(ex_x)) begin
        report_mismatch("px_x", px_x, ex_x);
      end
      if (px_y !== SCREEN_Y_WIDTH'(ex_y)) begin
        report_mismatch("px_y", px_y, ex_y);
      end
      active = (ex_x < H_ACTIVE) && (ex_y < V_ACTIVE);
      if (de !== active) begin
        report_mismatch("de", de, active);
      end
      if (de === 1'b1) begin
        de_count++;
        blk     = VRAM_ADDR_WIDTH'((ex_y / 4) * 256 + ex_x / 4);  // Block row, block column
        exp_rgb = truncate_color(exp_pal[vram[blk][PAL_INDEX_WIDTH-1:0]]);
        if (rgb !== exp_rgb) begin
          report_mismatch("rgb", rgb, exp_rgb);
        end
      end else if (rgb !== '0) begin
        report_mismatch("rgb", rgb, 0);
      end
      if (vram_en === 1'b1 &&
          (vram_addr[7:0] >= H_ACTIVE / 4 || vram_addr[15:8] >= V_ACTIVE / 4)) begin
        report_failure("vram_en high for a block in the blanking area");
      end
      ex_x++;
      if (ex_x == H_TOTAL) begin
        ex_x = 0;
        ex_y++;
        if (ex_y == V_TOTAL) begin
          ex_y = 0;
          checks++;
          if (de_count != H_ACTIVE * V_ACTIVE) begin
            report_mismatch("de count", de_count, H_ACTIVE * V_ACTIVE);
          end
          de_count = 0;
        end
      end
      @(negedge clk);
    end

    $display("Finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== palette_ram.sv ====
`timescale 1ns/1ps

module palette_ram (
  input  logic                               clk,
  input  logic                               rst_n,
  input  gpu_pkg::pal_req_t                  pal_req,
  output logic [gpu_pkg::MPU_DATA_WIDTH-1:0] pal_rdata,
  output logic                               pal_rvalid,
  input  gpu_pkg::fetch_t                    fetch,
  output gpu_pkg::lookup_t                   lookup
);
  import gpu_pkg::*;

  localparam int NUM_LANES = PAL_DATA_WIDTH / 8;  // Blue, green, red

  logic [PAL_DATA_WIDTH-1:0]  mem [PAL_ENTRIES];
  logic [PAL_INDEX_WIDTH-1:0] host_index;
  logic                       host_hi;      // Odd address, red byte
  logic [NUM_LANES-1:0]       lane_we;
  logic [PAL_DATA_WIDTH-1:0]  lane_wdata;

  // Two host addresses per entry
  assign host_index = pal_req.addr[PAL_ADDR_WIDTH-1:1];
  assign host_hi    = pal_req.addr[0];

  // Byte lane steering
  assign lane_we[0] = pal_req.wr && !host_hi && pal_req.be[0];  // Blue
  assign lane_we[1] = pal_req.wr && !host_hi && pal_req.be[1];  // Green
  assign lane_we[2] = pal_req.wr && host_hi && pal_req.be[0];   // Red from low byte
  assign lane_wdata = {pal_req.wdata[7:0], pal_req.wdata};

  // Host port, byte-enabled write
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_we[i]) begin
        mem[host_index][i*8 +: 8] <= lane_wdata[i*8 +: 8];
      end
    end
  end

  // Host port read, one cycle latency
  always_ff @(posedge clk) begin
    if (pal_req.rd) begin
      if (host_hi) begin
        pal_rdata <= {8'h00, mem[host_index][23:16]};  // Red, zero extended
      end else begin
        pal_rdata <= mem[host_index][15:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pal_rvalid <= 1'b0;
    end else begin
      pal_rvalid <= pal_req.rd;
    end
  end

  // Display port, reads every cycle
  // Same-cycle host write is not visible here yet
  always_ff @(posedge clk) begin
    lookup.x     <= fetch.x;
    lookup.y     <= fetch.y;
    lookup.color <= mem[fetch.index];
    if (!rst_n) begin
      lookup.blank <= 1'b0;
    end else begin
      lookup.blank <= fetch.blank;
    end
  end

  // Host issues one kind of access per cycle
  a_no_wr_rd: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(pal_req.wr && pal_req.rd)
  );

endmodule

// ==== scan_timing.sv ====
`timescale 1ns/1ps

module scan_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_TOTAL  = 800,
  parameter int V_ACTIVE = 480,
  parameter int V_TOTAL  = 525
) (
  input  logic           clk,
  input  logic           rst_n,
  output gpu_pkg::scan_t scan
);
  import gpu_pkg::*;

  localparam logic [SCREEN_X_WIDTH-1:0] X_LAST = SCREEN_X_WIDTH'(H_TOTAL - 1);
  localparam logic [SCREEN_Y_WIDTH-1:0] Y_LAST = SCREEN_Y_WIDTH'(V_TOTAL - 1);
  localparam logic [SCREEN_X_WIDTH-1:0] X_VIS  = SCREEN_X_WIDTH'(H_ACTIVE);
  localparam logic [SCREEN_Y_WIDTH-1:0] Y_VIS  = SCREEN_Y_WIDTH'(V_ACTIVE);

  logic [SCREEN_X_WIDTH-1:0] next_x;
  logic [SCREEN_Y_WIDTH-1:0] next_y;
  logic                      next_blank;

  // Next position in raster order
  always_comb begin
    next_x = scan.x + 1'b1;
    next_y = scan.y;
    if (scan.x == X_LAST) begin
      next_x = '0;  // End of line
      if (scan.y == Y_LAST) begin
        next_y = '0;  // End of frame
      end else begin
        next_y = scan.y + 1'b1;
      end
    end
  end

  // Blank decode on the next position so it lines up with the counters
  assign next_blank = (next_x >= X_VIS) || (next_y >= Y_VIS);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      scan <= '0;  // Start at the top left, visible
    end else begin
      scan.x     <= next_x;
      scan.y     <= next_y;
      scan.blank <= next_blank;
    end
  end

  // Counters never run past the totals
  a_x_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    scan.x < SCREEN_X_WIDTH'(H_TOTAL)
  );

  a_y_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    scan.y < SCREEN_Y_WIDTH'(V_TOTAL)
  );

endmodule

// ==== vram_fetch.sv ====
`timescale 1ns/1ps

module vram_fetch (
  input  logic                                clk,
  input  logic                                rst_n,
  input  gpu_pkg::scan_t                      scan,
  output logic [gpu_pkg::VRAM_ADDR_WIDTH-1:0] vram_addr,
  output logic                                vram_en,
  input  logic [gpu_pkg::VRAM_DATA_WIDTH-1:0] vram_data,
  output gpu_pkg::fetch_t                     fetch
);
  import gpu_pkg::*;

  scan_t                     req_q;     // Pixel whose read is in flight
  logic [VRAM_ADDR_WIDTH-1:0] blk_addr;

  // One VRAM word covers a 4x4 pixel block
  assign blk_addr = {scan.y[SCREEN_Y_WIDTH-1:2], scan.x[SCREEN_X_WIDTH-1:2]};

  // Stage 1, issue the read
  always_ff @(posedge clk) begin
    vram_addr <= blk_addr;
    req_q.x   <= scan.x;
    req_q.y   <= scan.y;
    if (!rst_n) begin
      vram_en     <= 1'b0;
      req_q.blank <= 1'b0;
    end else begin
      vram_en     <= !scan.blank;  // No reads in blanking
      req_q.blank <= scan.blank;
    end
  end

  // Stage 2, word returns from the synchronous VRAM
  always_ff @(posedge clk) begin
    fetch.x <= req_q.x;
    fetch.y <= req_q.y;
    // Upper data bits are spare, blank pixels get index zero
    fetch.index <= req_q.blank ? '0 : vram_data[PAL_INDEX_WIDTH-1:0];
    if (!rst_n) begin
      fetch.blank <= 1'b0;
    end else begin
      fetch.blank <= req_q.blank;
    end
  end

  // Read only issued for a pixel that was visible a cycle earlier
  a_en_active: assert property (
    @(posedge clk) disable iff (!rst_n)
    vram_en |-> !$past(scan.blank)
  );

endmodule
